// File: hdl/vga_line_fetch.sv
`default_nettype none

module vga_line_fetch (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire vga_pkg::vga_cfg_t     cfg,
	input  wire vga_pkg::vga_timing_t  tim,
	input  wire logic [31:0]           sram_data,
	input  wire logic                  sram_rdy,
	output logic [31:0]                sram_addr,
	output logic                       sram_read,
	output vga_pkg::vga_pixel_t        pix
);

	import vga_pkg::*;

	fetch_state_t state;
	logic [7:0]   pos;       // word index within the row
	logic [8:0]   row;       // row being fetched
	logic         last_word;
	logic         take;      // a word is accepted this cycle

	// two line buffers, one filled while the other is shown
	logic [31:0]  line_buf [2][words_per_line];

	logic [31:0]  show_word;
	logic [7:0]   show_byte;
	logic         show;

	assign last_word = (pos == 8'(words_per_line - 1));
	assign take      = (state == fetch_busy) && cfg.enable && sram_rdy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_idle;
			pos   <= '0;
			row   <= '0;
		end else begin
			case (state)
				fetch_idle: begin
					if (tim.fetch_start && cfg.enable) begin
						state <= fetch_busy;
						pos   <= '0;
						row   <= tim.fetch_row;
					end
				end
				fetch_busy: begin
					if (!cfg.enable) begin
						state <= fetch_idle;  // abandon the row when turned off
					end else if (sram_rdy) begin
						pos <= pos + 8'd1;
						if (last_word) begin
							state <= fetch_idle;
						end
					end
				end
				default: state <= fetch_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			line_buf[row[0]][pos] <= sram_data;  // half picked by row parity
		end
	end

	assign sram_read = (state == fetch_busy) && cfg.enable;
	assign sram_addr = cfg.fb_ptr + 32'(row) * 32'(line_bytes) + 32'({pos, 2'b00});

	// display side, word by x/4 and byte by x[1:0], msb is leftmost
	assign show_word = line_buf[tim.y[0]][tim.x[9:2]];
	assign show      = !tim.blank && cfg.enable;

	always_comb begin
		case (tim.x[1:0])
			2'd0:    show_byte = show_word[31:24];
			2'd1:    show_byte = show_word[23:16];
			2'd2:    show_byte = show_word[15:8];
			default: show_byte = show_word[7:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pix <= pix_reset;
		end else begin
			pix.hs  <= tim.hs;
			pix.vs  <= tim.vs;
			pix.rgb <= show ? show_byte : 8'h00;
		end
	end

	a_read_needs_enable: assert property (@(posedge clk) disable iff (rst)
		sram_read |-> cfg.enable)
		else $error("sram_read high while disabled");

	// the previous row must be complete before the next one is requested
	a_fetch_done_in_time: assert property (@(posedge clk) disable iff (rst)
		tim.fetch_start |-> (state == fetch_idle))
		else $error("fetch_start for row %0d while state=%s at word %0d",
			tim.fetch_row, state.name(), pos);

endmodule

`default_nettype wire

// File: hdl/vga_pkg.sv
`default_nettype none

package vga_pkg;

	// horizontal timing, in clocks
	localparam int h_pulse  = 96;
	localparam int h_back   = 48;
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_period = 800;

	// vertical timing, in lines
	localparam int v_pulse  = 2;
	localparam int v_back   = 29;
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_period = 521;

	localparam int h_start = h_pulse + h_back;    // first visible clock, 144
	localparam int h_end   = h_start + h_active;  // first clock of front porch, 784
	localparam int v_start = v_pulse + v_back;    // first visible line, 31
	localparam int v_end   = v_start + v_active;  // first line of front porch, 511

	// line fetch geometry
	localparam int words_per_line = 160;  // four pixels per word
	localparam int line_bytes     = 640;  // row stride in the frame buffer

	// register offsets on the data port
	localparam logic [31:0] reg_ctrl   = 32'h0000_0000;
	localparam logic [31:0] reg_fb_ptr = 32'h0000_0004;

	typedef enum logic {
		fetch_idle,
		fetch_busy
	} fetch_state_t;

	typedef struct packed {
		logic       hs;           // active low
		logic       vs;           // active low
		logic       blank;
		logic [9:0] x;            // 0 outside the active area
		logic [8:0] y;
		logic       fetch_start;  // one cycle, at the start of the line before a row
		logic [8:0] fetch_row;
	} vga_timing_t;

	typedef struct packed {
		logic       hs;
		logic       vs;
		logic [7:0] rgb;
	} vga_pixel_t;

	typedef struct packed {
		logic        enable;
		logic [31:0] fb_ptr;
	} vga_cfg_t;

	// values held while in reset, syncs inactive
	localparam vga_timing_t tim_reset = '{hs: 1'b1, vs: 1'b1, blank: 1'b1, default: '0};
	localparam vga_pixel_t  pix_reset = '{hs: 1'b1, vs: 1'b1, rgb: 8'h00};

endpackage

`default_nettype wire

// File: hdl/vga_regs.sv
`default_nettype none

module vga_regs (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              de,
	input  wire logic [1:0]        drw,
	input  wire logic [31:0]       daddr,
	input  wire logic [31:0]       din,
	output logic      [31:0]       dout,
	output vga_pkg::vga_cfg_t      cfg
);

	import vga_pkg::*;

	logic        enable;
	logic [31:0] fb_ptr;
	logic        wr_en;

	assign wr_en = de && drw[0];  // drw[0] marks a write cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			fb_ptr <= 32'h0000_0000;
		end else if (wr_en) begin
			case (daddr)
				reg_ctrl:   enable <= din[0];
				reg_fb_ptr: fb_ptr <= din;
				default:    ;  // unmapped offsets are dropped
			endcase
		end
	end

	// readback, anything but the control offset returns the pointer
	always_comb begin
		if (daddr == reg_ctrl) begin
			dout = {31'h0000_0000, enable};
		end else begin
			dout = fb_ptr;
		end
	end

	assign cfg.enable = enable;
	assign cfg.fb_ptr = fb_ptr;

endmodule

`default_nettype wire

// File: hdl/vga_timing.sv
`default_nettype none

module vga_timing (
	input  wire logic             clk,
	input  wire logic             rst,
	output vga_pkg::vga_timing_t  tim
);

	import vga_pkg::*;

	logic [9:0]  h;  // pixel counter from 0 to 799
	logic [9:0]  v;  // line counter from 0 to 520
	logic        h_last;
	logic        v_last;
	logic        h_vis;
	logic        v_vis;
	logic        pre_line;  // next line is visible
	vga_timing_t tim_next;

	assign h_last = (h == 10'(h_period - 1));
	assign v_last = (v == 10'(v_period - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			h <= '0;
			v <= '0;
		end else if (h_last) begin
			h <= '0;
			v <= v_last ? '0 : v + 10'd1;
		end else begin
			h <= h + 10'd1;
		end
	end

	assign h_vis    = (h >= 10'(h_start)) && (h < 10'(h_end));
	assign v_vis    = (v >= 10'(v_start)) && (v < 10'(v_end));
	assign pre_line = (v >= 10'(v_start - 1)) && (v < 10'(v_end - 1));

	always_comb begin
		tim_next             = '0;
		tim_next.hs          = (h >= 10'(h_pulse));
		tim_next.vs          = (v >= 10'(v_pulse));
		tim_next.blank       = !(h_vis && v_vis);
		tim_next.fetch_start = (h == 10'd0) && pre_line;
		if (h_vis) begin
			tim_next.x = h - 10'(h_start);
		end
		if (v_vis) begin
			tim_next.y = 9'(v - 10'(v_start));
		end
		if (pre_line) begin
			tim_next.fetch_row = 9'(v - 10'(v_start - 1));  // row shown on the next line
		end
	end

	// all fields leave on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			tim <= tim_reset;
		end else begin
			tim <= tim_next;
		end
	end

	a_counter_range: assert property (@(posedge clk) disable iff (rst)
		(h < 10'(h_period)) && (v < 10'(v_period)))
		else $error("timing counter out of range h=%0d v=%0d", h, v);

endmodule

`default_nettype wire

// File: hdl/vga_top.sv
`default_nettype none

module vga_top (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        de,
	input  wire logic [1:0]  drw,
	input  wire logic [31:0] daddr,
	input  wire logic [31:0] din,
	input  wire logic [31:0] sram_data,
	input  wire logic        sram_rdy,
	output logic      [31:0] dout,
	output logic      [7:0]  rgb,
	output logic             hs,
	output logic             vs,
	output logic      [31:0] sram_addr,
	output logic             sram_read
);

	import vga_pkg::*;

	vga_cfg_t    cfg;  // enable and frame buffer base
	vga_timing_t tim;
	vga_pixel_t  pix;

	vga_regs u_regs (
		.clk   (clk),
		.rst   (rst),
		.de    (de),
		.drw   (drw),
		.daddr (daddr),
		.din   (din),
		.dout  (dout),
		.cfg   (cfg)
	);

	vga_timing u_timing (
		.clk (clk),
		.rst (rst),
		.tim (tim)
	);

	vga_line_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.tim       (tim),
		.sram_data (sram_data),
		.sram_rdy  (sram_rdy),
		.sram_addr (sram_addr),
		.sram_read (sram_read),
		.pix       (pix)
	);

	// pixel stage already carries the syncs aligned with rgb
	assign rgb = pix.rgb;
	assign hs  = pix.hs;
	assign vs  = pix.vs;

endmodule

`default_nettype wire

// File: sources.f
+incdir+tb
hdl/vga_pkg.sv
hdl/vga_regs.sv
hdl/vga_timing.sv
hdl/vga_line_fetch.sv
hdl/vga_top.sv
tb/vga_mem_model.sv
tb/vga_tb.sv

// File: tb/vga_pattern.svh
// word stored at word address a, built so that every address bit changes the result
function automatic logic [31:0] pattern_word(input logic [29:0] a);
	logic [31:0] w;
	w = {2'b00, a} * 32'h9e37_79b1;  // odd multiplier, one to one over 32 bits
	return w ^ {a[13:0], a[29:12]} ^ 32'h5a5a_0f0f;
endfunction

// File: tb/vga_mem_model.sv
`default_nettype none

module vga_mem_model (
	input  wire logic        clk,
	input  wire logic        sram_read,
	input  wire logic [31:0] sram_addr,
	output logic      [31:0] sram_data,
	output logic             sram_rdy
);

	`include "vga_pattern.svh"

	integer     seed;
	logic [1:0] gap;  // idle cycles left before the next word

	initial begin
		seed      = 82;
		gap       = 2'd0;
		sram_data = 32'h0000_0000;
		sram_rdy  = 1'b0;
	end

	// driven on the falling edge so the DUT sees settled values at the rising edge
	always @(negedge clk) begin
		if (!sram_read) begin
			sram_rdy <= 1'b0;
			gap      <= 2'd0;  // first word of a row comes at once
		end else if (gap != 2'd0) begin
			sram_rdy <= 1'b0;
			gap      <= gap - 2'd1;
		end else begin
			sram_rdy  <= 1'b1;
			sram_data <= pattern_word(sram_addr[31:2]);
			gap       <= 2'({$random(seed)} % 3);  // 0 to 2 empty cycles
		end
	end

endmodule

`default_nettype wire

// File: tb/vga_tb.sv
`default_nettype none

module vga_tb;

	import vga_pkg::*;

	`include "vga_pattern.svh"

	logic        clk;
	logic        rst;
	logic        de;
	logic [1:0]  drw;
	logic [31:0] daddr;
	logic [31:0] din;
	logic [31:0] dout;
	logic [7:0]  rgb;
	logic        hs;
	logic        vs;
	logic [31:0] sram_addr;
	logic        sram_read;
	logic [31:0] sram_data;
	logic        sram_rdy;

	int          errs [1:6];  // failed checks per test
	int          tests_ok;
	int          tests_bad;
	int          shown;       // pixels compared in the first rows
	logic        chk_dark;    // frame with enable low
	logic        chk_show;    // frame with enable high
	logic [31:0] exp_fb;

	// monitor state rebuilt from the sync pins
	logic        prev_hs;
	logic        prev_vs;
	logic        seen_hs;
	logic        synced;
	logic        visible;
	logic [31:0] row_base;
	int          n_clk;   // rising edges since reset
	int          pin_h;   // samples since the last hs fall
	int          line;    // hs falls since the last vs fall
	int          hs_low;
	int          vs_low;
	int          vs_falls;

	vga_top UUT (
		.clk       (clk),
		.rst       (rst),
		.de        (de),
		.drw       (drw),
		.daddr     (daddr),
		.din       (din),
		.sram_data (sram_data),
		.sram_rdy  (sram_rdy),
		.dout      (dout),
		.rgb       (rgb),
		.hs        (hs),
		.vs        (vs),
		.sram_addr (sram_addr),
		.sram_read (sram_read)
	);

	vga_mem_model mem (
		.clk       (clk),
		.sram_read (sram_read),
		.sram_addr (sram_addr),
		.sram_data (sram_data),
		.sram_rdy  (sram_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [7:0] expected_rgb(input logic [31:0] fb_ptr, input int y,
		input int x);
		logic [31:0] byte_addr;
		logic [31:0] w;
		logic [7:0]  b;
		byte_addr = fb_ptr + 32'(y) * 32'd640 + 32'(x);
		w         = pattern_word(byte_addr[31:2]);
		case (byte_addr[1:0])  // leftmost pixel in the top byte
			2'd0:    b = w[31:24];
			2'd1:    b = w[23:16];
			2'd2:    b = w[15:8];
			default: b = w[7:0];
		endcase
		return b;
	endfunction

	task automatic check_eq(input int t, input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
			errs[t]++;
		end
	endtask

	task automatic reg_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] rw);
		@(negedge clk);
		de    = 1'b1;
		drw   = rw;
		daddr = addr;
		din   = data;
		@(negedge clk);
		de  = 1'b0;
		drw = 2'b00;
	endtask

	task automatic reg_expect(input int t, input logic [31:0] addr, input logic [31:0] exp);
		@(negedge clk);
		daddr = addr;
		#1;  // dout is combinational
		check_eq(t, $sformatf("dout at 0x%0h", addr), exp, dout);
	endtask

	task automatic report_test(input int t, input string name);
		if (errs[t] == 0) begin
			tests_ok++;
			$display("test %0d %s: ok", t, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: failed with %0d errors", t, name, errs[t]);
		end
	endtask

	// compares the pins against the rules on every rising edge
	always @(posedge clk) begin
		if (rst) begin
			prev_hs = 1'b1;
			prev_vs = 1'b1;
			seen_hs = 1'b0;
			synced  = 1'b0;
			n_clk   = 0;
			pin_h   = 0;
			line    = 0;
			hs_low  = 0;
			vs_low  = 0;
		end else begin
			n_clk++;
			if (prev_hs && !hs) begin
				if (!seen_hs) begin
					check_eq(3, "first hs fall clock", 2, n_clk - 1);  // sample trails by one
				end else begin
					check_eq(3, "hs period", h_period, pin_h + 1);
				end
				seen_hs = 1'b1;
				pin_h   = 0;
				if (prev_vs && !vs) begin
					if (synced) begin
						check_eq(3, "lines per frame", v_period, line + 1);
					end
					synced = 1'b1;
					line   = 0;
					vs_falls++;
				end else begin
					line++;
				end
			end else begin
				pin_h++;
			end
			if (!hs) begin
				hs_low++;
			end else begin
				if (!prev_hs && seen_hs) begin
					check_eq(3, "hs low clocks", h_pulse, hs_low);
				end
				hs_low = 0;
			end
			if (!vs) begin
				vs_low++;
			end else begin
				if (!prev_vs && synced) begin
					check_eq(3, "vs low clocks", v_pulse * h_period, vs_low);
				end
				vs_low = 0;
			end
			if (synced) begin
				visible = (pin_h >= h_start) && (pin_h < h_end) && (line >= v_start) &&
					(line < v_end);
				if (chk_dark) begin
					check_eq(4, "rgb", 0, rgb);
					check_eq(4, "sram_read", 0, sram_read);
				end
				if (chk_show) begin
					if (!visible) begin
						check_eq(6, "rgb", 0, rgb);
					end else if (line - v_start < 4) begin
						check_eq(5, "rgb", expected_rgb(exp_fb, line - v_start, pin_h - h_start),
							rgb);
						shown++;
					end
					if (sram_read) begin
						row_base = exp_fb + 32'(line - (v_start - 1)) * 32'd640;  // row of next line
						assert ((line >= v_start - 1) && (line < v_end - 1) &&
							(sram_addr >= row_base) && (sram_addr < row_base + 32'd640))
						else begin
							$display("Error at %0t: sram_addr expected 0x%0h..0x%0h, got 0x%0h",
								$time, row_base, row_base + 32'd639, sram_addr);
							errs[5]++;
						end
					end
				end
			end
			prev_hs = hs;
			prev_vs = vs;
		end
	end

	initial begin
		rst       = 1'b1;
		de        = 1'b0;
		drw       = 2'b00;
		daddr     = 32'h0000_0000;
		din       = 32'h0000_0000;
		exp_fb    = 32'h0000_0000;
		chk_dark  = 1'b1;
		chk_show  = 1'b0;
		tests_ok  = 0;
		tests_bad = 0;
		shown     = 0;
		vs_falls  = 0;
		for (int i = 1; i <= 6; i++) begin
			errs[i] = 0;
		end
		repeat (2) @(negedge clk);
		rst = 1'b0;

		check_eq(1, "hs", 1, hs);
		check_eq(1, "vs", 1, vs);
		check_eq(1, "rgb", 0, rgb);
		check_eq(1, "sram_read", 0, sram_read);
		check_eq(1, "dout at 0x0", 0, dout);
		reg_expect(1, 32'h4, 0);
		report_test(1, "reset state");

		// first frame runs with enable low while the monitor checks syncs and black
		wait (vs_falls == 2);
		@(negedge clk);
		chk_dark = 1'b0;
		chk_show = 1'b1;
		report_test(4, "disabled output");

		reg_write(32'h4, 32'h1234_5678, 2'b01);
		reg_expect(2, 32'h4, 32'h1234_5678);
		reg_write(32'h0, 32'hffff_ffff, 2'b01);
		reg_expect(2, 32'h0, 32'h0000_0001);
		reg_write(32'h4, 32'hdead_beef, 2'b10);  // read cycle stores nothing
		reg_write(32'h8, 32'hffff_fffe, 2'b01);  // unmapped offset
		reg_expect(2, 32'h0, 32'h0000_0001);
		reg_expect(2, 32'h4, 32'h1234_5678);
		reg_write(32'h0, 32'h0000_0000, 2'b01);
		reg_write(32'h4, 32'h0000_0000, 2'b01);
		reg_expect(2, 32'h0, 32'h0000_0000);
		reg_expect(2, 32'h4, 32'h0000_0000);
		report_test(2, "register access");

		// still on line 0 of the second frame and well before the first prefetch
		exp_fb = 32'd4096;
		reg_write(32'h4, exp_fb, 2'b01);
		reg_write(32'h0, 32'h0000_0001, 2'b01);
		wait (vs_falls == 3);
		@(negedge clk);
		chk_show = 1'b0;
		check_eq(5, "pixels compared", 4 * 640, shown);
		report_test(3, "sync timing");
		report_test(5, "pixel display");
		report_test(6, "blanking");

		$display("tests: %0d ok, %0d failed", tests_ok, tests_bad);
		if (tests_bad == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		int limit;
		int cycles;
		limit  = 3 * h_period * v_period + 1000;  // three frames and some slack
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
